/* design/seed_pkg.sv */
`default_nettype none

package seed_pkg;

	// --------------------------------------------------
	// engine dimensions
	// --------------------------------------------------
	localparam int NUM_LANES    = 4;
	localparam int LANE_W       = 2;   // lane index, also the memory tag
	localparam int MAX_READS    = 16;
	localparam int READ_NUM_W   = 4;
	localparam int READ_LEN     = 16;  // bases per read at most
	localparam int LEN_W        = 5;
	localparam int BWT_LEN      = 256; // indexed text length, initial l
	localparam int OCC_W        = 32;  // counts and addresses
	localparam int LOAD_W       = 64;
	localparam int RESULT_DEPTH = 4;

	// 2-bit nucleotide code, A C G T
	typedef logic [1:0] base_t;

	// one read as handed to a lane
	typedef struct packed {
		logic [READ_NUM_W-1:0]     read_num;
		logic [LEN_W-1:0]          len;
		base_t [READ_LEN-1:0]      bases;    // base j in bits 2j+1:2j
	} read_desc_t;

	// cnt[c] = number of text symbols smaller than c
	typedef struct packed {
		logic [3:0][OCC_W-1:0]     cnt;
	} l2_table_t;

	// occurrence lookup at both interval ends
	typedef struct packed {
		logic [LANE_W-1:0]         tag;
		logic [OCC_W-1:0]          addr_k;
		logic [OCC_W-1:0]          addr_l;
	} dram_req_t;

	typedef struct packed {
		logic [LANE_W-1:0]         tag;
		logic [3:0][OCC_W-1:0]     occ_k;    // occ(c, k) for c = 0..3
		logic [3:0][OCC_W-1:0]     occ_l;    // occ(c, l)
	} occ_resp_t;

	// final interval of one read
	typedef struct packed {
		logic [READ_NUM_W-1:0]     read_num;
		logic [LEN_W-1:0]          match_len;
		logic [OCC_W-1:0]          k;
		logic [OCC_W-1:0]          l;
	} seed_result_t;

endpackage

`default_nettype wire

/* design/read_buffer.sv */
`default_nettype none

module read_buffer (
	input  wire                               clk_32ui_i,
	input  wire                               reset_i,
	input  wire                               load_valid_i,
	input  wire [seed_pkg::LOAD_W-1:0]        load_data_i,
	input  wire [seed_pkg::READ_NUM_W:0]      batch_size_i,
	output logic                              load_done_o,
	output seed_pkg::l2_table_t               l2_o,
	input  wire [seed_pkg::NUM_LANES-1:0]     lane_idle_i,
	output logic [seed_pkg::NUM_LANES-1:0]    lane_start_o,
	output seed_pkg::read_desc_t              desc_o,
	output logic [seed_pkg::READ_NUM_W:0]     batch_size_o
);
	import seed_pkg::*;

	logic [READ_NUM_W+1:0]   word_cnt_q; // two L2 words, then reads
	logic [READ_NUM_W:0]     batch_q;
	logic [READ_NUM_W:0]     sent_q;     // reads already dispatched
	logic [2*READ_LEN-1:0]   bases_mem [MAX_READS];
	logic [LEN_W-1:0]        len_mem [MAX_READS];
	logic [READ_NUM_W-1:0]   wr_idx;
	logic [READ_NUM_W-1:0]   rd_idx;
	logic [NUM_LANES-1:0]    avail;
	logic [NUM_LANES-1:0]    pick;
	logic                    load_fire;
	logic                    dispatch;

	assign load_fire = load_valid_i && !load_done_o;
	assign wr_idx    = READ_NUM_W'(word_cnt_q - 2'd2);
	assign rd_idx    = sent_q[READ_NUM_W-1:0];

	// --------------------------------------------------
	// load stream
	// --------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			word_cnt_q  <= '0;
			batch_q     <= '0;
			load_done_o <= 1'b0;
		end else if (load_fire) begin
			word_cnt_q <= word_cnt_q + 1'b1;
			if (word_cnt_q == '0)
				batch_q <= batch_size_i; // sampled with word 0
			if (word_cnt_q == {1'b0, batch_q} + 1'b1)
				load_done_o <= 1'b1;     // last read word
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (load_fire) begin
			if (word_cnt_q == 0) begin
				l2_o.cnt[0] <= load_data_i[OCC_W-1:0];
				l2_o.cnt[1] <= load_data_i[2*OCC_W-1:OCC_W];
			end else if (word_cnt_q == 1) begin
				l2_o.cnt[2] <= load_data_i[OCC_W-1:0];
				l2_o.cnt[3] <= load_data_i[2*OCC_W-1:OCC_W];
			end else begin
				bases_mem[wr_idx] <= load_data_i[2*READ_LEN-1:0];
				len_mem[wr_idx]   <= load_data_i[2*READ_LEN +: LEN_W];
			end
		end
	end

	// --------------------------------------------------
	// dispatch to lowest idle lane
	// --------------------------------------------------
	// a lane still shows idle during its start pulse
	assign avail    = lane_idle_i & ~lane_start_o;
	assign pick     = avail & (~avail + 1'b1);
	assign dispatch = load_done_o && (sent_q < batch_q) && (|avail);

	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			lane_start_o <= '0;
			sent_q       <= '0;
		end else begin
			lane_start_o <= dispatch ? pick : '0;
			if (dispatch)
				sent_q <= sent_q + 1'b1;
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (dispatch) begin
			desc_o.read_num <= rd_idx; // arrival order
			desc_o.len      <= len_mem[rd_idx];
			desc_o.bases    <= bases_mem[rd_idx];
		end
	end

	assign batch_size_o = batch_q;

	// lane stays idle through its own start pulse
	start_to_idle: assert property (@(posedge clk_32ui_i) disable iff (reset_i)
		(lane_start_o & ~lane_idle_i) == '0);

endmodule

`default_nettype wire

/* design/ext_lane.sv */
`default_nettype none

module ext_lane #(
	parameter int LANE_ID = 0
) (
	input  wire                           clk_32ui_i,
	input  wire                           reset_i,
	input  wire                           start_i,
	input  wire seed_pkg::read_desc_t     desc_i,
	input  wire seed_pkg::l2_table_t      l2_i,
	output logic                          idle_o,
	output logic                          req_valid_o,
	output seed_pkg::dram_req_t           req_o,
	input  wire                           req_grant_i,
	input  wire                           resp_valid_i,
	input  wire seed_pkg::occ_resp_t      resp_i,
	output logic                          res_valid_o,
	output seed_pkg::seed_result_t        res_o,
	input  wire                           res_grant_i
);
	import seed_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,  // request held until granted
		S_WAIT, // one lookup outstanding
		S_DONE  // result held until granted
	} state_t;

	state_t                        state_q;
	read_desc_t                    desc_q;
	logic [OCC_W-1:0]              k_q;
	logic [OCC_W-1:0]              l_q;
	logic [$clog2(READ_LEN)-1:0]   pos_q;
	logic [LEN_W-1:0]              match_q;
	base_t                         cur_base;
	logic [OCC_W-1:0]              new_k;
	logic [OCC_W-1:0]              new_l;
	logic                          resp_hit;
	logic                          empty_next;

	assign resp_hit   = resp_valid_i && (resp_i.tag == LANE_W'(LANE_ID));
	assign cur_base   = desc_q.bases[pos_q];
	assign new_k      = l2_i.cnt[cur_base] + resp_i.occ_k[cur_base];
	assign new_l      = l2_i.cnt[cur_base] + resp_i.occ_l[cur_base];
	assign empty_next = (new_k >= new_l);

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: if (start_i) state_q <= (desc_i.len == '0) ? S_DONE : S_REQ;
				S_REQ:  if (req_grant_i) state_q <= S_WAIT;
				S_WAIT: if (resp_hit) state_q <= (empty_next || pos_q == '0) ? S_DONE : S_REQ;
				S_DONE: if (res_grant_i) state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// interval and position
	always_ff @(posedge clk_32ui_i) begin
		if (state_q == S_IDLE && start_i) begin
			desc_q  <= desc_i;
			k_q     <= '0;
			l_q     <= OCC_W'(BWT_LEN);
			pos_q   <= desc_i.len[$clog2(READ_LEN)-1:0] - 1'b1; // last base first
			match_q <= '0;
		end else if (state_q == S_WAIT && resp_hit && !empty_next) begin
			k_q     <= new_k;
			l_q     <= new_l;
			match_q <= match_q + 1'b1;
			pos_q   <= pos_q - 1'b1; // wraps after base 0, unused then
		end
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------
	assign idle_o      = (state_q == S_IDLE);
	assign req_valid_o = (state_q == S_REQ);
	assign res_valid_o = (state_q == S_DONE);

	always_comb begin
		req_o.tag       = LANE_W'(LANE_ID);
		req_o.addr_k    = k_q;
		req_o.addr_l    = l_q;
		res_o.read_num  = desc_q.read_num;
		res_o.match_len = match_q;
		res_o.k         = k_q;
		res_o.l         = l_q;
	end

	// tags from memory must follow this lane's own request
	resp_in_wait: assert property (@(posedge clk_32ui_i) disable iff (reset_i)
		resp_hit |-> state_q == S_WAIT);

endmodule

`default_nettype wire

/* design/lane_arbiter.sv */
`default_nettype none

module lane_arbiter #(
	parameter type payload_t = logic,
	parameter int  N         = 4
) (
	input  wire              clk_32ui_i,
	input  wire              reset_i,
	input  wire [N-1:0]      req_i,
	input  wire payload_t    payload_i [N],
	input  wire              ready_i,
	output logic             valid_o,
	output payload_t         payload_o,
	output logic [N-1:0]     grant_o
);

	typedef logic [$clog2(N)-1:0] idx_t;

	idx_t ptr_q;  // last granted requester
	idx_t sel;
	logic found;

	// search starts one past the last grant
	always_comb begin
		int idx;
		found = 1'b0;
		sel   = ptr_q;
		for (int i = 1; i <= N; i++) begin
			idx = (int'(ptr_q) + i) % N;
			if (!found && req_i[idx]) begin
				found = 1'b1;
				sel   = idx_t'(idx);
			end
		end
	end

	assign valid_o   = found && ready_i;
	assign payload_o = payload_i[sel];
	assign grant_o   = valid_o ? (N'(1) << sel) : '0;

	always_ff @(posedge clk_32ui_i) begin
		if (reset_i)
			ptr_q <= idx_t'(N - 1); // lane 0 wins first
		else if (valid_o)
			ptr_q <= sel;
	end

	// a waiting requester holds its level until granted
	req_held: assert property (@(posedge clk_32ui_i) disable iff (reset_i)
		(req_i & ~grant_o) != '0 |=> ($past(req_i & ~grant_o) & ~req_i) == '0);

endmodule

`default_nettype wire

/* design/result_collector.sv */
`default_nettype none

module result_collector (
	input  wire                               clk_32ui_i,
	input  wire                               reset_i,
	input  wire                               res_valid_i,
	input  wire seed_pkg::seed_result_t       res_i,
	input  wire [seed_pkg::READ_NUM_W:0]      batch_size_i,
	output logic                              res_ready_o,
	output logic                              output_request_o,
	input  wire                               output_permit_i,
	output logic                              output_valid_o,
	output seed_pkg::seed_result_t            output_data_o,
	output logic                              output_finish_o
);
	import seed_pkg::*;

	seed_result_t                      fifo_mem [RESULT_DEPTH];
	logic [$clog2(RESULT_DEPTH)-1:0]   wr_ptr_q;
	logic [$clog2(RESULT_DEPTH)-1:0]   rd_ptr_q;
	logic [$clog2(RESULT_DEPTH):0]     count_q;
	logic [READ_NUM_W:0]               delivered_q;
	logic                              push;
	logic                              pop;

	// --------------------------------------------------
	// result FIFO
	// --------------------------------------------------
	assign res_ready_o      = (count_q != RESULT_DEPTH);
	assign output_request_o = (count_q != '0);
	assign push             = res_valid_i;
	assign pop              = output_request_o && output_permit_i;

	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_q + push - pop;
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (push)
			fifo_mem[wr_ptr_q] <= res_i;
		if (pop)
			output_data_o <= fifo_mem[rd_ptr_q]; // valid one cycle after permit
	end

	// --------------------------------------------------
	// delivery and batch finish
	// --------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			output_valid_o  <= 1'b0;
			delivered_q     <= '0;
			output_finish_o <= 1'b0;
		end else begin
			output_valid_o <= pop;
			if (output_valid_o) begin
				delivered_q <= delivered_q + 1'b1;
				if (delivered_q + 1'b1 == batch_size_i)
					output_finish_o <= 1'b1;
			end
		end
	end

	// the result arbiter is gated by res_ready_o
	no_push_full: assert property (@(posedge clk_32ui_i) disable iff (reset_i)
		push |-> count_q != RESULT_DEPTH);

endmodule

`default_nettype wire

/* design/seed_top.sv */
`default_nettype none

module seed_top (
	input  wire                               clk_32ui_i,
	input  wire                               reset_i,

	// batch load
	input  wire                               load_valid_i,
	input  wire [seed_pkg::LOAD_W-1:0]        load_data_i,
	input  wire [seed_pkg::READ_NUM_W:0]      batch_size_i,
	output logic                              load_done_o,

	// occurrence memory
	output logic                              dram_valid_o,
	output seed_pkg::dram_req_t               dram_req_o,
	input  wire                               dram_get_i,
	input  wire seed_pkg::occ_resp_t          occ_resp_i,

	// result port
	output logic                              output_request_o,
	input  wire                               output_permit_i,
	output logic                              output_valid_o,
	output seed_pkg::seed_result_t            output_data_o,
	output logic                              output_finish_o
);
	import seed_pkg::*;

	l2_table_t               l2;
	read_desc_t              desc;
	logic [READ_NUM_W:0]     batch_size;
	logic [NUM_LANES-1:0]    lane_idle;
	logic [NUM_LANES-1:0]    lane_start;

	logic [NUM_LANES-1:0]    req_valid;
	dram_req_t               lane_req [NUM_LANES];
	logic [NUM_LANES-1:0]    req_grant;

	logic [NUM_LANES-1:0]    res_valid;
	seed_result_t            lane_res [NUM_LANES];
	logic [NUM_LANES-1:0]    res_grant;
	logic                    res_arb_valid;
	seed_result_t            res_arb;
	logic                    res_ready;

	read_buffer u_read_buffer (
		.clk_32ui_i   (clk_32ui_i),
		.reset_i      (reset_i),
		.load_valid_i (load_valid_i),
		.load_data_i  (load_data_i),
		.batch_size_i (batch_size_i),
		.load_done_o  (load_done_o),
		.l2_o         (l2),
		.lane_idle_i  (lane_idle),
		.lane_start_o (lane_start),
		.desc_o       (desc),
		.batch_size_o (batch_size)
	);

	// --------------------------------------------------
	// extension lanes
	// --------------------------------------------------
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		ext_lane #(.LANE_ID(g)) u_lane (
			.clk_32ui_i   (clk_32ui_i),
			.reset_i      (reset_i),
			.start_i      (lane_start[g]),
			.desc_i       (desc),
			.l2_i         (l2),
			.idle_o       (lane_idle[g]),
			.req_valid_o  (req_valid[g]),
			.req_o        (lane_req[g]),
			.req_grant_i  (req_grant[g]),
			.resp_valid_i (dram_get_i),  // every lane sees it, tag picks
			.resp_i       (occ_resp_i),
			.res_valid_o  (res_valid[g]),
			.res_o        (lane_res[g]),
			.res_grant_i  (res_grant[g])
		);
	end

	// memory has no back-pressure
	lane_arbiter #(.payload_t(dram_req_t), .N(NUM_LANES)) u_req_arb (
		.clk_32ui_i (clk_32ui_i),
		.reset_i    (reset_i),
		.req_i      (req_valid),
		.payload_i  (lane_req),
		.ready_i    (1'b1),
		.valid_o    (dram_valid_o),
		.payload_o  (dram_req_o),
		.grant_o    (req_grant)
	);

	lane_arbiter #(.payload_t(seed_result_t), .N(NUM_LANES)) u_res_arb (
		.clk_32ui_i (clk_32ui_i),
		.reset_i    (reset_i),
		.req_i      (res_valid),
		.payload_i  (lane_res),
		.ready_i    (res_ready),
		.valid_o    (res_arb_valid),
		.payload_o  (res_arb),
		.grant_o    (res_grant)
	);

	result_collector u_collector (
		.clk_32ui_i       (clk_32ui_i),
		.reset_i          (reset_i),
		.res_valid_i      (res_arb_valid),
		.res_i            (res_arb),
		.batch_size_i     (batch_size),
		.res_ready_o      (res_ready),
		.output_request_o (output_request_o),
		.output_permit_i  (output_permit_i),
		.output_valid_o   (output_valid_o),
		.output_data_o    (output_data_o),
		.output_finish_o  (output_finish_o)
	);

endmodule

`default_nettype wire

/* bench/fm_model.svh */
`ifndef FM_MODEL_SVH
`define FM_MODEL_SVH

// --------------------------------------------------
// reference FM index over a random text
// --------------------------------------------------
base_t       bwt [BWT_LEN];
int unsigned occ_tab [4][BWT_LEN+1]; // occ(c, i) counts c in bwt[0..i-1]
int unsigned l2_tab [4];             // symbols smaller than c

function automatic void build_index();
	int unsigned total [4];
	for (int c = 0; c < 4; c++) begin
		total[c]      = 0;
		occ_tab[c][0] = 0;
	end
	for (int i = 0; i < BWT_LEN; i++) begin
		bwt[i] = base_t'($urandom_range(0, 3));
		for (int c = 0; c < 4; c++)
			occ_tab[c][i+1] = occ_tab[c][i] + ((int'(bwt[i]) == c) ? 1 : 0);
		total[bwt[i]]++;
	end
	l2_tab[0] = 0;
	for (int c = 1; c < 4; c++)
		l2_tab[c] = l2_tab[c-1] + total[c-1];
endfunction

function automatic int unsigned occ_at(int c, logic [OCC_W-1:0] addr);
	if (addr > BWT_LEN)
		return occ_tab[c][BWT_LEN]; // bad address, caught by the request check
	return occ_tab[c][addr];
endfunction

// last base first, stop before the interval goes empty
function automatic void backward_search(input logic [31:0] bases, input int len,
		output int mlen, output int k, output int l, output int steps);
	int  c;
	int  nk;
	int  nl;
	bit  stop;
	k     = 0;
	l     = BWT_LEN;
	mlen  = 0;
	steps = 0;
	stop  = 1'b0;
	for (int pos = len - 1; pos >= 0 && !stop; pos--) begin
		c  = int'(bases[2*pos +: 2]);
		nk = l2_tab[c] + occ_tab[c][k];
		nl = l2_tab[c] + occ_tab[c][l];
		steps++; // one lookup per base tried
		if (nk >= nl) begin
			stop = 1'b1;
		end else begin
			k = nk;
			l = nl;
			mlen++;
		end
	end
endfunction

`endif

/* bench/seed_tb.sv */
`default_nettype none

module seed_tb;
	import seed_pkg::*;

	localparam int unsigned SEED        = 32'h7daa_55e1;
	localparam int          NUM_BATCHES = 3;
	localparam int          LAT_MIN     = 1;
	localparam int          LAT_MAX     = 6;
	localparam int          TIMEOUT     = NUM_BATCHES * MAX_READS * READ_LEN * 10 + 2000;

	logic                  clk;
	logic                  reset_i;
	logic                  load_valid_i;
	logic [LOAD_W-1:0]     load_data_i;
	logic [READ_NUM_W:0]   batch_size_i;
	logic                  load_done_o;
	logic                  dram_valid_o;
	dram_req_t             dram_req_o;
	logic                  dram_get_i;
	occ_resp_t             occ_resp_i;
	logic                  output_request_o;
	logic                  output_permit_i;
	logic                  output_valid_o;
	seed_result_t          output_data_o;
	logic                  output_finish_o;

	// batch under test
	int          batch_n;
	logic [31:0] read_bases [MAX_READS];
	int          read_len [MAX_READS];
	int          exp_len [MAX_READS];
	int          exp_k [MAX_READS];
	int          exp_l [MAX_READS];
	bit          seen [MAX_READS];
	int          exp_steps;
	int          result_count;
	int          req_count;

	int cycle;
	int check_count;
	int err_count;
	bit prev_pop;     // request and permit in the last cycle
	bit finish_seen;
	bit permit_en;

	dram_req_t pend_req [$]; // lookups in flight
	int        pend_due [$];

	`include "fm_model.svh"

	seed_top dut0 (
		.clk_32ui_i       (clk),
		.reset_i          (reset_i),
		.load_valid_i     (load_valid_i),
		.load_data_i      (load_data_i),
		.batch_size_i     (batch_size_i),
		.load_done_o      (load_done_o),
		.dram_valid_o     (dram_valid_o),
		.dram_req_o       (dram_req_o),
		.dram_get_i       (dram_get_i),
		.occ_resp_i       (occ_resp_i),
		.output_request_o (output_request_o),
		.output_permit_i  (output_permit_i),
		.output_valid_o   (output_valid_o),
		.output_data_o    (output_data_o),
		.output_finish_o  (output_finish_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("** Error: %s = 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle);
		end
	endtask

	function automatic logic [LOAD_W-1:0] load_word(int w);
		if (w == 0)
			return {l2_tab[1], l2_tab[0]}; // low half first
		if (w == 1)
			return {l2_tab[3], l2_tab[2]};
		return {27'd0, LEN_W'(read_len[w-2]), read_bases[w-2]};
	endfunction

	function automatic occ_resp_t make_response(dram_req_t req);
		occ_resp_t resp;
		resp.tag = req.tag;
		for (int c = 0; c < 4; c++) begin
			resp.occ_k[c] = occ_at(c, req.addr_k);
			resp.occ_l[c] = occ_at(c, req.addr_l);
		end
		return resp;
	endfunction

	// --------------------------------------------------
	// memory responder and output permit
	// --------------------------------------------------
	initial begin
		int hit;
		dram_get_i      = 1'b0;
		occ_resp_i      = '0;
		output_permit_i = 1'b0;
		forever begin
			@(negedge clk);
			hit        = -1;
			dram_get_i = 1'b0;
			if (!reset_i)
				foreach (pend_due[i])
					if (hit < 0 && pend_due[i] <= cycle)
						hit = i;
			if (hit >= 0) begin
				occ_resp_i = make_response(pend_req[hit]);
				dram_get_i = 1'b1;
				pend_req.delete(hit);
				pend_due.delete(hit);
			end
			output_permit_i = permit_en && ($urandom_range(0, 9) < 6); // random gaps
		end
	end

	// --------------------------------------------------
	// monitor and timeout
	// --------------------------------------------------
	always @(posedge clk) begin
		seed_result_t r;
		if (cycle >= TIMEOUT) begin
			$display("timeout after %0d cycles, the batch never finished", cycle);
			$display("Test failures found");
			$finish;
		end else if (reset_i) begin
			prev_pop    = 1'b0;
			finish_seen = 1'b0;
			pend_req.delete();
			pend_due.delete();
			cycle++;
		end else begin
			if (dram_valid_o) begin
				check_value("dram_req_o.addr_k < addr_l", dram_req_o.addr_k < dram_req_o.addr_l, 1);
				check_value("dram_req_o.addr_l <= BWT_LEN", dram_req_o.addr_l <= BWT_LEN, 1);
				pend_req.push_back(dram_req_o);
				pend_due.push_back(cycle + $urandom_range(LAT_MIN, LAT_MAX));
				req_count++;
			end
			check_value("output_valid_o", output_valid_o, prev_pop);
			if (output_valid_o) begin
				r = output_data_o;
				if (r.read_num >= batch_n || seen[r.read_num]) begin
					$display("read %0d delivered twice or outside the batch", r.read_num);
					err_count++;
				end else begin
					seen[r.read_num] = 1'b1;
					check_value("output_data_o.match_len", r.match_len, exp_len[r.read_num]);
					check_value("output_data_o.k", r.k, exp_k[r.read_num]);
					check_value("output_data_o.l", r.l, exp_l[r.read_num]);
				end
				result_count++;
			end
			if (finish_seen && !output_finish_o) begin
				$display("output_finish_o dropped before reset");
				err_count++;
			end
			if (output_finish_o && result_count < batch_n) begin
				$display("output_finish_o rose before the final result");
				err_count++;
			end
			finish_seen = finish_seen || output_finish_o;
			prev_pop    = output_request_o && output_permit_i;
			cycle++;
		end
	end

	// --------------------------------------------------
	// batches
	// --------------------------------------------------
	initial begin
		int          one_idx;
		int          steps;
		int          batch_err;
		reset_i      = 1'b1;
		load_valid_i = 1'b0;
		load_data_i  = '0;
		batch_size_i = '0;
		void'($urandom(SEED));
		build_index();
		for (int b = 0; b < NUM_BATCHES; b++) begin
			batch_err = err_count;
			permit_en = 1'b0;
			reset_i   = 1'b1;
			repeat (10) @(negedge clk);
			check_value("dram_valid_o", dram_valid_o, 0);
			check_value("load_done_o", load_done_o, 0);
			check_value("output_request_o", output_request_o, 0);
			check_value("output_valid_o", output_valid_o, 0);
			check_value("output_finish_o", output_finish_o, 0);
			reset_i = 1'b0;

			batch_n      = $urandom_range(1, MAX_READS);
			one_idx      = $urandom_range(0, batch_n - 1); // at least one single-base read
			exp_steps    = 0;
			result_count = 0;
			req_count    = 0;
			for (int i = 0; i < batch_n; i++) begin
				read_len[i]   = (i == one_idx) ? 1 : $urandom_range(1, READ_LEN);
				read_bases[i] = $urandom();
				seen[i]       = 1'b0;
				backward_search(read_bases[i], read_len[i], exp_len[i], exp_k[i], exp_l[i], steps);
				exp_steps += steps;
			end

			for (int w = 0; w < batch_n + 2; w++) begin
				check_value("load_done_o", load_done_o, 0);
				load_valid_i = 1'b1;
				batch_size_i = (READ_NUM_W+1)'(batch_n);
				load_data_i  = load_word(w);
				@(negedge clk);
			end
			load_valid_i = 1'b0;
			check_value("load_done_o", load_done_o, 1);

			// no permit yet so the FIFO fills and the lanes stall
			repeat (READ_LEN * 12) @(negedge clk);
			permit_en = 1'b1;

			while (!output_finish_o)
				@(negedge clk);
			repeat (20) @(negedge clk); // finish must hold, nothing more may arrive
			check_value("result count", result_count, batch_n);
			check_value("dram request count", req_count, exp_steps);
			for (int i = 0; i < batch_n; i++)
				if (!seen[i]) begin
					$display("read %0d produced no result", i);
					err_count++;
				end
			$display("batch %0d: %0d reads, %0d lookups, %0d errors", b, batch_n, req_count,
				err_count - batch_err);
		end
		$display("%0d batches, %0d checks, %0d errors", NUM_BATCHES, check_count, err_count);
		if (err_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+bench
design/seed_pkg.sv
design/read_buffer.sv
design/ext_lane.sv
design/lane_arbiter.sv
design/result_collector.sv
design/seed_top.sv
bench/seed_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the seed search testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module seed_tb -f build.f -o seed_sim
./obj_dir/seed_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation clean"
exit 0
